//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bit_manip_decoder
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh test/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass message
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+src
src/bmu_decode_pkg.sv
src/decode_if.sv
src/imm_group_decoder.sv
src/reg_group_decoder.sv
src/bmu_issue_stage.sv
src/bit_manip_decoder.sv
test/tb_bit_manip_decoder.sv

//--- src/bit_manip_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bit_manip_decoder
    import bmu_decode_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           instr_valid_i,
    input  instr_t         instr_i,
    output logic           instr_ready_o,
    output logic           out_valid_o,
    output logic           out_exception_o,
    output bmu_op_type_e   out_op_type_o,
    output bmu_operation_e out_operation_o,
    output reg_addr_t      out_rs1_o,
    output reg_addr_t      out_rs2_o,
    output reg_addr_t      out_rd_o,
    output data_word_t     out_imm_o,
    output logic           out_imm_valid_o,
    input  logic           credit_i
);

    decode_if imm_dec ();    // OP-IMM group result
    decode_if reg_dec ();    // OP group result

    imm_group_decoder u_imm_dec (
        .instr_i (instr_i),
        .dec_o   (imm_dec)
    );

    reg_group_decoder u_reg_dec (
        .instr_i (instr_i),
        .dec_o   (reg_dec)
    );

    bmu_issue_stage u_issue (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .credit_i        (credit_i),
        .imm_dec_i       (imm_dec),
        .reg_dec_i       (reg_dec),
        .instr_ready_o   (instr_ready_o),
        .out_valid_o     (out_valid_o),
        .out_exception_o (out_exception_o),
        .out_op_type_o   (out_op_type_o),
        .out_operation_o (out_operation_o),
        .out_rs1_o       (out_rs1_o),
        .out_rs2_o       (out_rs2_o),
        .out_rd_o        (out_rd_o),
        .out_imm_o       (out_imm_o),
        .out_imm_valid_o (out_imm_valid_o)
    );

endmodule : bit_manip_decoder

`default_nettype wire

//--- src/bmu_decode_pkg.sv
`default_nettype none

`include "bmu_defs.svh"

package bmu_decode_pkg;

    typedef logic [31:0]                   instr_t;
    typedef logic [`BMU_XLEN-1:0]          data_word_t;
    typedef logic [`BMU_REG_ADDR_W-1:0]    reg_addr_t;
    typedef logic [`BMU_CREDIT_W-1:0]      credit_cnt_t;

    // Operation class picks the functional block
    typedef enum logic [2:0] {
        LOGICOP,
        COUNT,
        EXTEND,
        ROTATE,
        BYTEOP,
        SHADD,
        COMPARE
    } bmu_op_type_e;

    typedef enum logic [4:0] {
        BSET,    BCLR,   BINV,   BEXT,   // Single bit
        CLZ,     CTZ,    CPOP,           // Counts
        SEXTB,   SEXTH,  ZEXTH,          // Extensions
        ROL,     ROR,
        REV8,    ORCB,
        SH1ADD,  SH2ADD, SH3ADD,         // Address generation
        MIN,     MINU,   MAX,    MAXU,
        XNOR,    ORN,    ANDN            // Inverted logic
    } bmu_operation_e;

endpackage : bmu_decode_pkg

`default_nettype wire

//--- src/bmu_defs.svh
`ifndef BMU_DEFS_SVH
`define BMU_DEFS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Operand and immediate width
`define BMU_XLEN 32

// Register index width
`define BMU_REG_ADDR_W 5

////////////////////////////////////////
// Downstream flow control
////////////////////////////////////////

// Entries in the downstream buffer
`define BMU_CREDITS 4

// Must hold the value BMU_CREDITS
`define BMU_CREDIT_W 3

`endif

//--- src/bmu_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "bmu_defs.svh"

module bmu_issue_stage
    import bmu_decode_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           instr_valid_i,
    input  logic           credit_i,
    decode_if.issue        imm_dec_i,
    decode_if.issue        reg_dec_i,
    output logic           instr_ready_o,
    output logic           out_valid_o,
    output logic           out_exception_o,
    output bmu_op_type_e   out_op_type_o,
    output bmu_operation_e out_operation_o,
    output reg_addr_t      out_rs1_o,
    output reg_addr_t      out_rs2_o,
    output reg_addr_t      out_rd_o,
    output data_word_t     out_imm_o,
    output logic           out_imm_valid_o
);

    credit_cnt_t    credit_cnt;
    logic           take;
    logic           exception;
    bmu_op_type_e   sel_op_type;
    bmu_operation_e sel_operation;
    reg_addr_t      sel_rs1;
    reg_addr_t      sel_rs2;
    reg_addr_t      sel_rd;
    data_word_t     sel_imm;
    logic           sel_imm_valid;

    assign instr_ready_o = (credit_cnt != '0);
    assign take          = instr_valid_i & instr_ready_o;

    // Illegal is only raised by the group that hit
    assign exception = ~(imm_dec_i.hit | reg_dec_i.hit) | imm_dec_i.illegal
                     | reg_dec_i.illegal;

    always_comb begin : group_select
        sel_op_type   = bmu_op_type_e'(0);
        sel_operation = bmu_operation_e'(0);
        sel_rs1       = '0;
        sel_rs2       = '0;
        sel_rd        = '0;
        sel_imm       = '0;
        sel_imm_valid = 1'b0;

        if (!exception) begin
            if (imm_dec_i.hit) begin
                sel_op_type   = imm_dec_i.op_type;
                sel_operation = imm_dec_i.operation;
                sel_rs1       = imm_dec_i.rs1;
                sel_rs2       = imm_dec_i.rs2;
                sel_rd        = imm_dec_i.rd;
                sel_imm       = imm_dec_i.imm;
                sel_imm_valid = imm_dec_i.imm_valid;
            end else begin
                sel_op_type   = reg_dec_i.op_type;
                sel_operation = reg_dec_i.operation;
                sel_rs1       = reg_dec_i.rs1;
                sel_rs2       = reg_dec_i.rs2;
                sel_rd        = reg_dec_i.rd;
                sel_imm       = reg_dec_i.imm;
                sel_imm_valid = reg_dec_i.imm_valid;
            end
        end
    end : group_select

    ////////////////////////////////////////
    // Credits and output register
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin : credit_counter
        if (!rst_n_i) begin
            credit_cnt <= credit_cnt_t'(`BMU_CREDITS);
        end else if (take && !credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (credit_i && !take) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end : credit_counter

    always_ff @(posedge clk_i or negedge rst_n_i) begin : issue_reg
        if (!rst_n_i) begin
            out_valid_o     <= 1'b0;
            out_exception_o <= 1'b0;
            out_op_type_o   <= bmu_op_type_e'(0);
            out_operation_o <= bmu_operation_e'(0);
            out_rs1_o       <= '0;
            out_rs2_o       <= '0;
            out_rd_o        <= '0;
            out_imm_o       <= '0;
            out_imm_valid_o <= 1'b0;
        end else begin
            out_valid_o <= take;                 // One beat per take
            if (take) begin
                out_exception_o <= exception;
                out_op_type_o   <= sel_op_type;
                out_operation_o <= sel_operation;
                out_rs1_o       <= sel_rs1;
                out_rs2_o       <= sel_rs2;
                out_rd_o        <= sel_rd;
                out_imm_o       <= sel_imm;
                out_imm_valid_o <= sel_imm_valid;
            end
        end
    end : issue_reg

    credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_cnt <= credit_cnt_t'(`BMU_CREDITS));

    // Downstream returns only entries it was given
    no_spare_credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_i |-> (credit_cnt != credit_cnt_t'(`BMU_CREDITS)));

    single_group_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(imm_dec_i.hit && reg_dec_i.hit));

endmodule : bmu_issue_stage

`default_nettype wire

//--- src/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if
    import bmu_decode_pkg::*;
();

    logic           hit;        // Opcode belongs to the group
    logic           illegal;    // Reserved field inside the group
    bmu_op_type_e   op_type;
    bmu_operation_e operation;
    reg_addr_t      rs1;
    reg_addr_t      rs2;
    reg_addr_t      rd;
    data_word_t     imm;
    logic           imm_valid;

    modport decoder (
        output hit, illegal, op_type, operation, rs1, rs2, rd, imm, imm_valid
    );

    modport issue (
        input hit, illegal, op_type, operation, rs1, rs2, rd, imm, imm_valid
    );

endinterface : decode_if

`default_nettype wire

//--- src/imm_group_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module imm_group_decoder
    import bmu_decode_pkg::*;
(
    input  instr_t    instr_i,
    decode_if.decoder dec_o
);

    localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
    localparam logic [11:0] REV8_IMM   = 12'b011010011000;
    localparam logic [11:0] ORCB_IMM   = 12'b001010000111;

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    reg_addr_t      rs1_f;
    reg_addr_t      shamt_f;       // rs2 slot holds shamt or sub-opcode
    reg_addr_t      rd_f;
    logic           reserved;
    logic           shamt_form;
    logic           form_ok;
    bmu_op_type_e   op_type;
    bmu_operation_e operation;

    assign opcode  = instr_i[6:0];
    assign rd_f    = instr_i[11:7];
    assign funct3  = instr_i[14:12];
    assign rs1_f   = instr_i[19:15];
    assign shamt_f = instr_i[24:20];
    assign funct7  = instr_i[31:25];

    ////////////////////////////////////////
    // Encoding match
    ////////////////////////////////////////

    always_comb begin : imm_decode
        reserved   = 1'b0;
        shamt_form = 1'b0;
        op_type    = LOGICOP;
        operation  = BSET;

        case (funct3)
            3'b001: begin
                case (funct7)
                    7'b0010100: begin
                        operation  = BSET;
                        shamt_form = 1'b1;
                    end
                    7'b0100100: begin
                        operation  = BCLR;
                        shamt_form = 1'b1;
                    end
                    7'b0110100: begin
                        operation  = BINV;
                        shamt_form = 1'b1;
                    end
                    7'b0110000: begin
                        op_type = COUNT;
                        case (shamt_f)    // Unary forms
                            5'b00000: operation = CLZ;
                            5'b00001: operation = CTZ;
                            5'b00010: operation = CPOP;
                            5'b00100: begin
                                op_type   = EXTEND;
                                operation = SEXTB;
                            end
                            5'b00101: begin
                                op_type   = EXTEND;
                                operation = SEXTH;
                            end
                            default: reserved = 1'b1;
                        endcase
                    end
                    default: reserved = 1'b1;
                endcase
            end
            3'b101: begin
                if (instr_i[31:20] == REV8_IMM) begin
                    op_type   = BYTEOP;
                    operation = REV8;
                end else if (instr_i[31:20] == ORCB_IMM) begin
                    op_type   = BYTEOP;
                    operation = ORCB;
                end else begin
                    case (funct7)
                        7'b0100100: begin
                            operation  = BEXT;
                            shamt_form = 1'b1;
                        end
                        7'b0110000: begin
                            op_type    = ROTATE;
                            operation  = ROR;
                            shamt_form = 1'b1;
                        end
                        default: reserved = 1'b1;
                    endcase
                end
            end
            default: reserved = 1'b1;    // Base ISA shifts and arithmetic
        endcase
    end : imm_decode

    assign dec_o.hit     = (opcode == OPC_OP_IMM);
    assign dec_o.illegal = dec_o.hit & reserved;
    assign form_ok       = dec_o.hit & ~reserved;

    assign dec_o.op_type   = form_ok ? op_type : bmu_op_type_e'(0);
    assign dec_o.operation = form_ok ? operation : bmu_operation_e'(0);
    assign dec_o.rs1       = form_ok ? rs1_f : '0;
    assign dec_o.rs2       = '0;                     // Slot holds the shamt
    assign dec_o.rd        = form_ok ? rd_f : '0;
    assign dec_o.imm_valid = form_ok & shamt_form;
    assign dec_o.imm       = (form_ok & shamt_form) ? data_word_t'(shamt_f) : '0;

endmodule : imm_group_decoder

`default_nettype wire

//--- src/reg_group_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module reg_group_decoder
    import bmu_decode_pkg::*;
(
    input  instr_t    instr_i,
    decode_if.decoder dec_o
);

    localparam logic [6:0] OPC_OP = 7'b0110011;

    // funct7 patterns of the ratified encoding
    localparam logic [6:0] F7_BSET  = 7'b0010100;
    localparam logic [6:0] F7_BCLR  = 7'b0100100;
    localparam logic [6:0] F7_BINV  = 7'b0110100;
    localparam logic [6:0] F7_ROT   = 7'b0110000;
    localparam logic [6:0] F7_SHADD = 7'b0010000;
    localparam logic [6:0] F7_MINMAX = 7'b0000101;
    localparam logic [6:0] F7_INV   = 7'b0100000;
    localparam logic [6:0] F7_ZEXTH = 7'b0000100;

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    reg_addr_t      rs1_f;
    reg_addr_t      rs2_f;
    reg_addr_t      rd_f;
    logic           reserved;
    logic           uses_rs2;
    logic           form_ok;
    bmu_op_type_e   op_type;
    bmu_operation_e operation;

    assign opcode = instr_i[6:0];
    assign rd_f   = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1_f  = instr_i[19:15];
    assign rs2_f  = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////
    // Encoding match
    ////////////////////////////////////////

    always_comb begin : reg_decode
        reserved  = 1'b0;
        uses_rs2  = 1'b1;
        op_type   = LOGICOP;
        operation = BSET;

        case (funct3)
            3'b001: begin
                case (funct7)
                    F7_BSET: operation = BSET;
                    F7_BCLR: operation = BCLR;
                    F7_BINV: operation = BINV;
                    F7_ROT: begin
                        op_type   = ROTATE;
                        operation = ROL;
                    end
                    default: reserved = 1'b1;
                endcase
            end
            3'b010: begin
                op_type   = SHADD;
                operation = SH1ADD;
                reserved  = (funct7 != F7_SHADD);
            end
            3'b100: begin
                case (funct7)
                    F7_SHADD: begin
                        op_type   = SHADD;
                        operation = SH2ADD;
                    end
                    F7_MINMAX: begin
                        op_type   = COMPARE;
                        operation = MIN;
                    end
                    F7_INV: operation = XNOR;
                    F7_ZEXTH: begin
                        op_type   = EXTEND;
                        operation = ZEXTH;
                        uses_rs2  = 1'b0;
                        reserved  = (rs2_f != '0);    // Unary form keeps rs2 slot at zero
                    end
                    default: reserved = 1'b1;
                endcase
            end
            3'b101: begin
                case (funct7)
                    F7_BCLR: operation = BEXT;        // Shares the BCLR pattern
                    F7_ROT: begin
                        op_type   = ROTATE;
                        operation = ROR;
                    end
                    F7_MINMAX: begin
                        op_type   = COMPARE;
                        operation = MINU;
                    end
                    default: reserved = 1'b1;
                endcase
            end
            3'b110: begin
                case (funct7)
                    F7_SHADD: begin
                        op_type   = SHADD;
                        operation = SH3ADD;
                    end
                    F7_MINMAX: begin
                        op_type   = COMPARE;
                        operation = MAX;
                    end
                    F7_INV: operation = ORN;
                    default: reserved = 1'b1;
                endcase
            end
            3'b111: begin
                case (funct7)
                    F7_INV: operation = ANDN;
                    F7_MINMAX: begin
                        op_type   = COMPARE;
                        operation = MAXU;
                    end
                    default: reserved = 1'b1;
                endcase
            end
            default: reserved = 1'b1;    // funct3 000 and 011
        endcase
    end : reg_decode

    assign dec_o.hit     = (opcode == OPC_OP);
    assign dec_o.illegal = dec_o.hit & reserved;
    assign form_ok       = dec_o.hit & ~reserved;

    assign dec_o.op_type   = form_ok ? op_type : bmu_op_type_e'(0);
    assign dec_o.operation = form_ok ? operation : bmu_operation_e'(0);
    assign dec_o.rs1       = form_ok ? rs1_f : '0;
    assign dec_o.rs2       = (form_ok & uses_rs2) ? rs2_f : '0;
    assign dec_o.rd        = form_ok ? rd_f : '0;
    assign dec_o.imm       = '0;      // Register forms only
    assign dec_o.imm_valid = 1'b0;

endmodule : reg_group_decoder

`default_nettype wire

//--- test/bmu_decoder_tests.txt
// instr    mode exc type oper rs1 rs2 rd immv imm
// mode 0 streams with credits, mode 1 withholds credits
28911093 0 0 0 00 02 00 01 1 09
49F31193 0 0 0 01 06 00 03 1 1F
68011293 0 0 0 02 02 00 05 1 00
48C15093 0 0 0 03 02 00 01 1 0C
60535513 0 0 3 0B 06 00 0A 1 05
60011093 0 0 1 04 02 00 01 0 00
60111093 0 0 1 05 02 00 01 0 00
60231193 0 0 1 06 06 00 03 0 00
60411293 0 0 2 07 02 00 05 0 00
60511093 0 0 2 08 02 00 01 0 00
69815093 0 0 4 0C 02 00 01 0 00
28735193 0 0 4 0D 06 00 03 0 00
283110B3 0 0 0 00 02 03 01 0 00
484112B3 0 0 0 01 02 04 05 0 00
687311B3 0 0 0 02 06 07 03 0 00
483150B3 0 0 0 03 02 03 01 0 00
60911533 0 0 3 0A 02 09 0A 0 00
60915533 0 0 3 0B 02 09 0A 0 00
203120B3 0 0 5 0E 02 03 01 0 00
203140B3 0 0 5 0F 02 03 01 0 00
203160B3 0 0 5 10 02 03 01 0 00
0A4341B3 0 0 6 11 06 04 03 0 00
0A4351B3 0 0 6 12 06 04 03 0 00
0A4361B3 0 0 6 13 06 04 03 0 00
0A4371B3 0 0 6 14 06 04 03 0 00
080142B3 0 0 2 09 02 00 05 0 00
407140B3 0 0 0 15 02 07 01 0 00
407160B3 0 0 0 16 02 07 01 0 00
407170B3 0 0 0 17 02 07 01 0 00
404371B3 1 0 0 17 06 04 03 0 00
60211513 1 0 1 06 02 00 0A 0 00
203130B3 1 1 0 00 00 00 00 0 00
61115293 1 0 3 0B 02 00 05 1 11
20934533 1 0 5 0F 06 09 0A 0 00
68131093 1 0 0 02 06 00 01 1 01
023110B3 0 1 0 00 00 00 00 0 00
403120B3 0 1 0 00 00 00 00 0 00
203170B3 0 1 0 00 00 00 00 0 00
60311093 0 1 0 00 00 00 00 0 00
00515093 0 1 0 00 00 00 00 0 00
081142B3 0 1 0 00 00 00 00 0 00
403100B3 0 1 0 00 00 00 00 0 00
00110093 0 1 0 00 00 00 00 0 00
123450B7 0 1 0 00 00 00 00 0 00
283110B2 0 1 0 00 00 00 00 0 00

//--- test/tb_bit_manip_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "bmu_defs.svh"

module tb_bit_manip_decoder
    import bmu_decode_pkg::*;
();

    localparam int MAX_TESTS  = 64;
    localparam int FIELDS     = 10;    // Columns per test line
    localparam int DRIVE_SKEW = 2;

    logic           clk_i;
    logic           rst_n_i;
    logic           instr_valid_i;
    instr_t         instr_i;
    logic           credit_i;
    logic           instr_ready_o;
    logic           out_valid_o;
    logic           out_exception_o;
    bmu_op_type_e   out_op_type_o;
    bmu_operation_e out_operation_o;
    reg_addr_t      out_rs1_o;
    reg_addr_t      out_rs2_o;
    reg_addr_t      out_rd_o;
    data_word_t     out_imm_o;
    logic           out_imm_valid_o;

    logic [31:0] test_mem [0:MAX_TESTS*FIELDS-1];
    int          num_tests;
    int          cycle_limit;
    int          cycle_count;
    int          seed;
    int          beats_seen;
    int          tests_passed;
    int          tests_failed;
    int          beat_fails;
    int          flow_fails;
    int          takes_total;
    int          burst_takes;
    int          credits_returned;
    logic        withhold;            // Downstream holds its credits
    logic        in_burst;
    int          credit_due_q[$];
    int          beat_due_q[$];       // Cycle in which each taken beat must show

    bit_manip_decoder dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .instr_ready_o   (instr_ready_o),
        .out_valid_o     (out_valid_o),
        .out_exception_o (out_exception_o),
        .out_op_type_o   (out_op_type_o),
        .out_operation_o (out_operation_o),
        .out_rs1_o       (out_rs1_o),
        .out_rs2_o       (out_rs2_o),
        .out_rd_o        (out_rd_o),
        .out_imm_o       (out_imm_o),
        .out_imm_valid_o (out_imm_valid_o),
        .credit_i        (credit_i)
    );

    function automatic logic [31:0] test_field(input int t, input int k);
        return test_mem[t*FIELDS+k];
    endfunction

    function automatic int field_mismatch(input string label, input string name,
                                          input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s %s: got %h, expected %h", label, name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout after %0d cycles, %0d of %0d beats seen",
                 cycle_count, beats_seen, num_tests);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////
    // Downstream model
    ////////////////////////////////////////

    task automatic compare_beat(input int t);
        string label;
        int    bad;
        label = $sformatf("test %0d", t);
        bad   = 0;
        bad += field_mismatch(label, "out_exception_o", 32'(out_exception_o), test_field(t, 2));
        bad += field_mismatch(label, "out_op_type_o", 32'(out_op_type_o), test_field(t, 3));
        bad += field_mismatch(label, "out_operation_o", 32'(out_operation_o), test_field(t, 4));
        bad += field_mismatch(label, "out_rs1_o", 32'(out_rs1_o), test_field(t, 5));
        bad += field_mismatch(label, "out_rs2_o", 32'(out_rs2_o), test_field(t, 6));
        bad += field_mismatch(label, "out_rd_o", 32'(out_rd_o), test_field(t, 7));
        bad += field_mismatch(label, "out_imm_valid_o", 32'(out_imm_valid_o), test_field(t, 8));
        bad += field_mismatch(label, "out_imm_o", 32'(out_imm_o), test_field(t, 9));
        if (bad == 0) begin
            tests_passed = tests_passed + 1;
        end else begin
            tests_failed = tests_failed + 1;
            beat_fails   = beat_fails + bad;
        end
        $display("%s instr %h: %s", label, test_field(t, 0), (bad == 0) ? "pass" : "fail");
    endtask

    initial begin : beat_monitor
        int due;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && out_valid_o) begin
                if (beat_due_q.size() == 0) begin
                    $display("Beat arrived in cycle %0d with no take before it", cycle_count);
                    flow_fails = flow_fails + 1;
                end else begin
                    due = beat_due_q.pop_front();
                    if (due != cycle_count) begin
                        $display("Beat arrived in cycle %0d, expected in cycle %0d",
                                 cycle_count, due);
                        flow_fails = flow_fails + 1;
                    end
                end
                if (beats_seen >= num_tests) begin
                    $display("Beat arrived with no instruction left to match it");
                    beat_fails = beat_fails + 1;
                end else begin
                    compare_beat(beats_seen);    // Beats follow instruction order
                end
                beats_seen = beats_seen + 1;
            end
        end
    end

    initial begin : credit_return
        int scheduled;
        int delay;
        seed      = 85839;
        scheduled = 0;
        credit_i  = 1'b0;
        forever begin
            @(posedge clk_i);
            #DRIVE_SKEW;
            while (scheduled < beats_seen) begin
                delay = {$random(seed)} % 4;    // 0 to 3 cycles
                credit_due_q.push_back(cycle_count + delay);
                scheduled = scheduled + 1;
            end
            if (!withhold && credit_due_q.size() > 0 && cycle_count >= credit_due_q[0]) begin
                credit_i = 1'b1;
                void'(credit_due_q.pop_front());
                credits_returned = credits_returned + 1;
            end else begin
                credit_i = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic drain_outstanding();
        @(posedge clk_i);
        #DRIVE_SKEW;
        instr_valid_i = 1'b0;
        @(negedge clk_i);
        while (takes_total != credits_returned) @(negedge clk_i);
    endtask

    task automatic start_burst();
        drain_outstanding();    // Counter back at full depth
        burst_takes = 0;
        withhold    = 1'b1;
        in_burst    = 1'b1;
    endtask

    task automatic end_burst();
        if (withhold) begin
            $display("instr_ready_o stayed high through the whole withheld-credit burst");
            flow_fails = flow_fails + 1;
            withhold   = 1'b0;
        end
        in_burst = 1'b0;
    endtask

    task automatic issue_test(input int t);
        logic took;
        @(posedge clk_i);
        #DRIVE_SKEW;
        instr_valid_i = 1'b1;
        instr_i       = test_field(t, 0);
        took          = 1'b0;
        while (!took) begin
            @(negedge clk_i);
            if (instr_ready_o) begin
                took        = 1'b1;    // Taken on the next rising edge
                takes_total = takes_total + 1;
                beat_due_q.push_back(cycle_count + 1);
                if (withhold) begin
                    burst_takes = burst_takes + 1;
                end
            end else if (withhold) begin
                if (burst_takes != `BMU_CREDITS) begin
                    $display("instr_ready_o fell after %0d takes, expected %0d",
                             burst_takes, `BMU_CREDITS);
                    flow_fails = flow_fails + 1;
                end else begin
                    $display("back-pressure: instr_ready_o fell after %0d takes", burst_takes);
                end
                withhold = 1'b0;
            end
        end
    endtask

    initial begin : stimulus
        int t;
        int i;
        int reset_bad;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        withhold      = 1'b0;
        in_burst      = 1'b0;
        for (i = 0; i < MAX_TESTS*FIELDS; i++) begin
            test_mem[i] = ~32'(i);              // Mode column never matches
        end
        $readmemh("test/bmu_decoder_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && test_field(num_tests, 1) <= 32'd1) begin
            num_tests = num_tests + 1;
        end
        cycle_limit = 8 * num_tests + 200;
        if (num_tests == 0) begin
            $display("No test lines could be read from the data file");
            flow_fails = flow_fails + 1;
        end

        repeat (16) @(posedge clk_i);
        #DRIVE_SKEW;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        reset_bad = field_mismatch("reset", "instr_ready_o", 32'(instr_ready_o), 32'd1);
        reset_bad += field_mismatch("reset", "out_valid_o", 32'(out_valid_o), 32'd0);
        reset_bad += field_mismatch("reset", "out_exception_o", 32'(out_exception_o), 32'd0);
        flow_fails = flow_fails + reset_bad;
        $display("reset state: %s", (reset_bad == 0) ? "pass" : "fail");

        for (t = 0; t < num_tests; t++) begin
            if (test_field(t, 1) == 32'd1 && !in_burst) begin
                start_burst();
            end else if (test_field(t, 1) == 32'd0 && in_burst) begin
                end_burst();
            end
            issue_test(t);
        end
        if (in_burst) begin
            end_burst();
        end
        drain_outstanding();

        $display("tests %0d, passed %0d, failed %0d, field mismatches %0d, flow failures %0d",
                 num_tests, tests_passed, tests_failed, beat_fails, flow_fails);
        if (beat_fails == 0 && flow_fails == 0 && tests_failed == 0
            && beats_seen == num_tests) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_bit_manip_decoder

`default_nettype wire
